// ==== cpuPkg.sv ====
// CPU package with opcodes, ALU codes, write-back selects and the instruction word formats
package cpuPkg;

  localparam int xlen        = 32;
  localparam int regIdxWidth = 5;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Major opcodes of the supported RV32I subset
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;

  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;
  localparam logic [2:0] f3Beq    = 3'b000;
  localparam logic [2:0] f3Bne    = 3'b001;
  localparam logic [2:0] f3Word   = 3'b010; // LW and SW
  localparam logic [6:0] f7Sub    = 7'b0100000;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request unit FSM states
  localparam logic [1:0] stIdle   = 2'd0;
  localparam logic [1:0] stFetch  = 2'd1;
  localparam logic [1:0] stDecode = 2'd2; // Instruction latched, waiting on decode
  localparam logic [1:0] stData   = 2'd3;

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt
  } aluOp_t;

  typedef enum logic [1:0] {
    wbAlu, wbMem, wbImm, wbPcPlus4
  } wbSel_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One instruction word seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
    } rType;
    struct packed {
      logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
      logic [4:0] rd; logic [6:0] opcode;
    } iType;
    struct packed {
      logic [6:0] immHi; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [4:0] immLo; logic [6:0] opcode;
    } sType;
    struct packed {
      logic imm12; logic [5:0] imm10to5; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [3:0] imm4to1; logic imm11; logic [6:0] opcode;
    } bType;
    struct packed {
      logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;
    } uType;
    struct packed {
      logic imm20; logic [9:0] imm10to1; logic imm11; logic [7:0] imm19to12;
      logic [4:0] rd; logic [6:0] opcode;
    } jType;
  } instr_t;

endpackage

// ==== cpuControl.sv ====
// Control unit decoding an instruction word into register selects, immediate and control lines
`timescale 1ns/1ps

module cpuControl (
  input  cpuPkg::instr_t                    instr_i,
  output logic [cpuPkg::regIdxWidth-1:0]    rs1_o,
  output logic [cpuPkg::regIdxWidth-1:0]    rs2_o,
  output logic [cpuPkg::regIdxWidth-1:0]    rd_o,
  output logic [cpuPkg::xlen-1:0]           imm_o,
  output cpuPkg::aluOp_t                    aluOp_o,
  output logic                              aluSrc_o,
  output logic                              regWrite_o,
  output cpuPkg::wbSel_t                    wbSel_o,
  output logic                              memRead_o,
  output logic                              memWrite_o,
  output logic                              branch_o,
  output logic                              branchNe_o,
  output logic                              jump_o
);

  always_comb begin
    rs1_o      = instr_i.rType.rs1;
    rs2_o      = instr_i.rType.rs2;
    rd_o       = instr_i.rType.rd;
    imm_o      = '0;
    aluOp_o    = cpuPkg::aluAdd;
    aluSrc_o   = 1'b0;
    regWrite_o = 1'b0; // Unknown opcodes fall through as a no-op
    wbSel_o    = cpuPkg::wbAlu;
    memRead_o  = 1'b0;
    memWrite_o = 1'b0;
    branch_o   = 1'b0;
    branchNe_o = 1'b0;
    jump_o     = 1'b0;
    case (instr_i.rType.opcode)
      cpuPkg::opOp: begin
        regWrite_o = 1'b1;
        case (instr_i.rType.funct3)
          cpuPkg::f3AddSub: aluOp_o = (instr_i.rType.funct7 == cpuPkg::f7Sub) ?
                                      cpuPkg::aluSub : cpuPkg::aluAdd;
          cpuPkg::f3Slt:    aluOp_o = cpuPkg::aluSlt;
          cpuPkg::f3Xor:    aluOp_o = cpuPkg::aluXor;
          cpuPkg::f3Or:     aluOp_o = cpuPkg::aluOr;
          cpuPkg::f3And:    aluOp_o = cpuPkg::aluAnd;
          default:          regWrite_o = 1'b0; // Shifts are not supported
        endcase
      end
      cpuPkg::opOpImm: begin
        imm_o      = {{20{instr_i.iType.imm[11]}}, instr_i.iType.imm};
        aluSrc_o   = 1'b1;
        regWrite_o = (instr_i.iType.funct3 == cpuPkg::f3AddSub); // ADDI only
      end
      cpuPkg::opLoad: begin
        imm_o      = {{20{instr_i.iType.imm[11]}}, instr_i.iType.imm};
        aluSrc_o   = 1'b1;
        memRead_o  = (instr_i.iType.funct3 == cpuPkg::f3Word);
        regWrite_o = memRead_o;
        wbSel_o    = cpuPkg::wbMem;
      end
      cpuPkg::opStore: begin
        imm_o      = {{20{instr_i.sType.immHi[6]}}, instr_i.sType.immHi, instr_i.sType.immLo};
        aluSrc_o   = 1'b1;
        memWrite_o = (instr_i.sType.funct3 == cpuPkg::f3Word);
      end
      cpuPkg::opLui: begin
        imm_o      = {instr_i.uType.imm, 12'h000};
        regWrite_o = 1'b1;
        wbSel_o    = cpuPkg::wbImm;
      end
      cpuPkg::opBranch: begin
        imm_o      = {{20{instr_i.bType.imm12}}, instr_i.bType.imm11,
                      instr_i.bType.imm10to5, instr_i.bType.imm4to1, 1'b0};
        aluOp_o    = cpuPkg::aluSub; // Zero flag gives equality
        branch_o   = (instr_i.bType.funct3 == cpuPkg::f3Beq);
        branchNe_o = (instr_i.bType.funct3 == cpuPkg::f3Bne);
      end
      cpuPkg::opJal: begin
        imm_o      = {{12{instr_i.jType.imm20}}, instr_i.jType.imm19to12,
                      instr_i.jType.imm11, instr_i.jType.imm10to1, 1'b0};
        regWrite_o = 1'b1;
        wbSel_o    = cpuPkg::wbPcPlus4; // Link address
        jump_o     = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== cpuRegFile.sv ====
// Register file with 32 general registers, two read ports and one write port, x0 tied to zero
`timescale 1ns/1ps

module cpuRegFile (
  input  logic                           clk,
  input  logic                           reset_i,
  input  logic                           commit_i,
  input  logic                           regWrite_i,
  input  logic [cpuPkg::regIdxWidth-1:0] rs1_i,
  input  logic [cpuPkg::regIdxWidth-1:0] rs2_i,
  input  logic [cpuPkg::regIdxWidth-1:0] rd_i,
  input  logic [cpuPkg::xlen-1:0]        writeData_i,
  output logic [cpuPkg::xlen-1:0]        readData1_o,
  output logic [cpuPkg::xlen-1:0]        readData2_o
);

  logic [cpuPkg::xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (commit_i && regWrite_i && (rd_i != '0)) begin // x0 never takes a write
      regs[rd_i] <= writeData_i;
    end
  end

  assign readData1_o = regs[rs1_i];
  assign readData2_o = regs[rs2_i];

  // An instruction targeting x0 must leave it at zero afterwards
  assert property (@(posedge clk) disable iff (reset_i)
    (commit_i && regWrite_i && (rd_i == '0)) |=> (regs[0] == '0));

endmodule

// ==== cpuExecute.sv ====
// Execute stage with operand select, ALU, result flags and write-back source select
`timescale 1ns/1ps

module cpuExecute (
  input  logic [cpuPkg::xlen-1:0] readData1_i,
  input  logic [cpuPkg::xlen-1:0] readData2_i,
  input  logic [cpuPkg::xlen-1:0] imm_i,
  input  logic [cpuPkg::xlen-1:0] pc_i,
  input  logic [cpuPkg::xlen-1:0] loadData_i,
  input  cpuPkg::aluOp_t          aluOp_i,
  input  logic                    aluSrc_i,
  input  cpuPkg::wbSel_t          wbSel_i,
  output logic [cpuPkg::xlen-1:0] aluResult_o,
  output logic [cpuPkg::xlen-1:0] writeData_o,
  output logic                    zero_o,
  output logic                    negative_o
);

  logic [cpuPkg::xlen-1:0] operandB;

  assign operandB = aluSrc_i ? imm_i : readData2_i; // Immediate for ADDI, loads and stores

  always_comb begin
    case (aluOp_i)
      cpuPkg::aluSub: aluResult_o = readData1_i - operandB;
      cpuPkg::aluAnd: aluResult_o = readData1_i & operandB;
      cpuPkg::aluOr:  aluResult_o = readData1_i | operandB;
      cpuPkg::aluXor: aluResult_o = readData1_i ^ operandB;
      cpuPkg::aluSlt: aluResult_o = {31'b0, $signed(readData1_i) < $signed(operandB)};
      default:        aluResult_o = readData1_i + operandB;
    endcase
  end

  assign zero_o     = (aluResult_o == '0);
  assign negative_o = aluResult_o[cpuPkg::xlen-1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write-back source
  always_comb begin
    case (wbSel_i)
      cpuPkg::wbMem:     writeData_o = loadData_i;
      cpuPkg::wbImm:     writeData_o = imm_i;       // LUI value is already shifted up
      cpuPkg::wbPcPlus4: writeData_o = pc_i + 32'd4;
      default:           writeData_o = aluResult_o;
    endcase
  end

endmodule

// ==== cpuPc.sv ====
// Program counter with sequential, branch and jump next-address selection
`timescale 1ns/1ps

module cpuPc (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    commit_i,
  input  logic                    branch_i,
  input  logic                    branchNe_i,
  input  logic                    jump_i,
  input  logic                    zero_i,
  input  logic [cpuPkg::xlen-1:0] imm_i,
  output logic [cpuPkg::xlen-1:0] pc_o
);

  logic takeTarget;

  assign takeTarget = jump_i | (branch_i & zero_i) | (branchNe_i & ~zero_i);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_o <= '0;
    end else if (commit_i) begin // PC moves only when an instruction retires
      pc_o <= takeTarget ? (pc_o + imm_i) : (pc_o + 32'd4);
    end
  end

  // Branch and jump offsets are only halfword aligned in the encoding
  assert property (@(posedge clk) disable iff (reset_i)
    commit_i |=> (pc_o[1:0] == 2'b00));

endmodule

// ==== cpuRequestUnit.sv ====
// Request unit sequencing instruction fetch and data access on the shared memory bus
`timescale 1ns/1ps

module cpuRequestUnit (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    enable_i,
  input  logic [cpuPkg::xlen-1:0] pc_i,
  input  logic [cpuPkg::xlen-1:0] dataAddr_i,
  input  logic [cpuPkg::xlen-1:0] storeData_i,
  input  logic                    memRead_i,
  input  logic                    memWrite_i,
  input  logic [cpuPkg::xlen-1:0] ramLoad_i,
  input  logic                    ramBusy_i,
  output logic [cpuPkg::xlen-1:0] ramAddr_o,
  output logic [cpuPkg::xlen-1:0] ramStore_o,
  output logic                    ramRead_o,
  output logic                    ramWrite_o,
  output logic [3:0]              ramSel_o,
  output cpuPkg::instr_t          instr_o,
  output logic [cpuPkg::xlen-1:0] loadData_o,
  output logic                    commit_o
);

  logic [1:0]              state, stateNext;
  logic                    memOp, dataDone;
  logic [cpuPkg::xlen-1:0] loadReg;

  assign memOp    = memRead_i | memWrite_i;
  assign dataDone = (state == cpuPkg::stData) && !ramBusy_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Phase sequencing
  always_comb begin
    stateNext = state;
    case (state)
      cpuPkg::stIdle:   if (enable_i) stateNext = cpuPkg::stFetch;
      cpuPkg::stFetch:  if (!ramBusy_i) stateNext = cpuPkg::stDecode;
      cpuPkg::stDecode: begin
        if (!memOp) stateNext = enable_i ? cpuPkg::stFetch : cpuPkg::stIdle;
        else if (enable_i) stateNext = cpuPkg::stData; // Hold here while frozen
      end
      default:          if (!ramBusy_i) stateNext = enable_i ? cpuPkg::stFetch : cpuPkg::stIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) state <= cpuPkg::stIdle;
    else         state <= stateNext;
  end

  always_ff @(posedge clk) begin
    if ((state == cpuPkg::stFetch) && !ramBusy_i) instr_o <= ramLoad_i;
    if (dataDone) loadReg <= ramLoad_i;
  end

  // The loaded word is written back at the same edge that completes the read
  assign loadData_o = dataDone ? ramLoad_i : loadReg;
  assign commit_o   = ((state == cpuPkg::stDecode) && !memOp) || dataDone;

  assign ramAddr_o  = (state == cpuPkg::stData) ? dataAddr_i : pc_i;
  assign ramStore_o = storeData_i;
  assign ramRead_o  = (state == cpuPkg::stFetch) || ((state == cpuPkg::stData) && memRead_i);
  assign ramWrite_o = (state == cpuPkg::stData) && memWrite_i;
  assign ramSel_o   = 4'b1111; // Word access only

  assert property (@(posedge clk) disable iff (reset_i) !(ramRead_o && ramWrite_o));

  // A stalled request keeps its strobes, address and store data
  assert property (@(posedge clk) disable iff (reset_i)
    ((ramRead_o || ramWrite_o) && ramBusy_i) |=>
      ($stable(ramRead_o) && $stable(ramWrite_o) && $stable(ramAddr_o) &&
       (!ramWrite_o || $stable(ramStore_o))));

endmodule

// ==== cpuTop.sv ====
// Core top level joining the single-cycle datapath to the external memory bus
`timescale 1ns/1ps

module cpuTop (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    enable_i,
  input  logic [cpuPkg::xlen-1:0] ramLoad_i,
  input  logic                    ramBusy_i,
  output logic [cpuPkg::xlen-1:0] ramAddr_o,
  output logic [cpuPkg::xlen-1:0] ramStore_o,
  output logic                    ramRead_o,
  output logic                    ramWrite_o,
  output logic [3:0]              ramSel_o
);

  cpuPkg::instr_t                  instr;
  cpuPkg::aluOp_t                  aluOp;
  cpuPkg::wbSel_t                  wbSel;
  logic [cpuPkg::regIdxWidth-1:0]  rs1, rs2, rd;
  logic [cpuPkg::xlen-1:0]         imm, pc, regData1, regData2, aluResult, writeData, loadData;
  logic aluSrc, regWrite, memRead, memWrite, branch, branchNe, jump, zero, commit;

  cpuRequestUnit u_request (
    .clk(clk), .reset_i(reset_i), .enable_i(enable_i),
    .pc_i(pc), .dataAddr_i(aluResult), .storeData_i(regData2),
    .memRead_i(memRead), .memWrite_i(memWrite),
    .ramLoad_i(ramLoad_i), .ramBusy_i(ramBusy_i),
    .ramAddr_o(ramAddr_o), .ramStore_o(ramStore_o), .ramRead_o(ramRead_o),
    .ramWrite_o(ramWrite_o), .ramSel_o(ramSel_o),
    .instr_o(instr), .loadData_o(loadData), .commit_o(commit));

  cpuControl u_control (
    .instr_i(instr), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
    .aluOp_o(aluOp), .aluSrc_o(aluSrc), .regWrite_o(regWrite), .wbSel_o(wbSel),
    .memRead_o(memRead), .memWrite_o(memWrite),
    .branch_o(branch), .branchNe_o(branchNe), .jump_o(jump));

  cpuRegFile u_regFile (
    .clk(clk), .reset_i(reset_i), .commit_i(commit), .regWrite_i(regWrite),
    .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd), .writeData_i(writeData),
    .readData1_o(regData1), .readData2_o(regData2));

  // Negative flag has no consumer in this instruction subset
  cpuExecute u_execute (
    .readData1_i(regData1), .readData2_i(regData2), .imm_i(imm), .pc_i(pc),
    .loadData_i(loadData), .aluOp_i(aluOp), .aluSrc_i(aluSrc), .wbSel_i(wbSel),
    .aluResult_o(aluResult), .writeData_o(writeData),
    .zero_o(zero), .negative_o());

  cpuPc u_pc (
    .clk(clk), .reset_i(reset_i), .commit_i(commit),
    .branch_i(branch), .branchNe_i(branchNe), .jump_i(jump), .zero_i(zero),
    .imm_i(imm), .pc_o(pc));

endmodule

// ==== tbMemModel.sv ====
// Bus memory model for the CPU core with random busy stretching, store tracking and protocol checks
`timescale 1ns/1ps

module tbMemModel (
  input  logic        clk,
  input  logic        reset_i,
  input  logic [31:0] ramAddr_i,
  input  logic [31:0] ramStore_i,
  input  logic        ramRead_i,
  input  logic        ramWrite_i,
  input  logic [3:0]  ramSel_i,
  input  int          busyMax_i,
  output logic [31:0] ramLoad_o,
  output logic        ramBusy_o,
  output logic [31:0] lastStoreAddr_o,
  output int          storeCount_o,
  output int          protocolErrors_o
);

  logic [31:0] mem [256];
  logic [31:0] prevAddr, prevStore;
  logic        prevRead, prevWrite, prevStall;
  int          busyLeft;
  int          seed = 24606;

  assign ramLoad_o = mem[ramAddr_i[9:2]]; // Word addressed, wraps above 1 KiB

  initial begin
    ramBusy_o        = 1'b0;
    busyLeft         = 0;
    prevStall        = 1'b0;
    storeCount_o     = 0;
    protocolErrors_o = 0;
    lastStoreAddr_o  = '0;
  end

  task automatic reportProtocol(string what);
    protocolErrors_o++;
    $display("Memory model at %0t ns: %s", $time, what);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus state is sampled at the edge, the response changes 1 ns later
  always @(posedge clk) begin
    logic        rst, rd, wr, busy;
    logic [31:0] addr, data;
    logic [3:0]  sel;
    rst  = reset_i;
    rd   = ramRead_i;
    wr   = ramWrite_i;
    busy = ramBusy_o;
    addr = ramAddr_i;
    data = ramStore_i;
    sel  = ramSel_i;
    #1;
    if (rst) begin
      storeCount_o = 0;
      busyLeft     = 0;
      prevStall    = 1'b0;
    end else begin
      if (rd && wr) reportProtocol("read and write strobes are high together");
      if (prevStall && (rd != prevRead || wr != prevWrite || addr != prevAddr ||
          (wr && data != prevStore))) reportProtocol("request changed while busy was high");
      if ((rd || wr) && sel != 4'hF) reportProtocol("byte select is not a full word");
      if (wr && !busy) begin // Store completes in this cycle
        mem[addr[9:2]]  = data;
        lastStoreAddr_o = addr;
        storeCount_o++;
      end
      if ((rd || wr) && busy) busyLeft--;
      else if (rd || wr) busyLeft = (busyMax_i > 0) ? {$random(seed)} % (busyMax_i + 1) : 0;
      prevStall = (rd || wr) && busy;
      prevRead  = rd;
      prevWrite = wr;
      prevAddr  = addr;
      prevStore = data;
    end
    ramBusy_o = (busyLeft != 0); // Next request waits out the remaining count
  end

endmodule

// ==== tbCpuTop.sv ====
// Directed testbench for the CPU core running small programs from the bus memory model
`timescale 1ns/1ps

module tbCpuTop;

  localparam int cycleLimit = 4000; // Six tests of up to 40 instructions at 8 cycles plus margin
  localparam int dataBase   = 'h200;

  logic        clk, reset, enable, ramBusy, ramRead, ramWrite;
  logic [31:0] ramLoad, ramAddr, ramStore, lastStoreAddr;
  logic [3:0]  ramSel;
  int          busyMax, storeCount, protocolErrors, cycles, checks, errors;
  logic [31:0] prog [$];

  cpuTop u_dut (
    .clk(clk), .reset_i(reset), .enable_i(enable), .ramLoad_i(ramLoad), .ramBusy_i(ramBusy),
    .ramAddr_o(ramAddr), .ramStore_o(ramStore), .ramRead_o(ramRead), .ramWrite_o(ramWrite),
    .ramSel_o(ramSel));

  tbMemModel u_mem (
    .clk(clk), .reset_i(reset), .ramAddr_i(ramAddr), .ramStore_i(ramStore),
    .ramRead_i(ramRead), .ramWrite_i(ramWrite), .ramSel_i(ramSel), .busyMax_i(busyMax),
    .ramLoad_o(ramLoad), .ramBusy_o(ramBusy), .lastStoreAddr_o(lastStoreAddr),
    .storeCount_o(storeCount), .protocolErrors_o(protocolErrors));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Timeout after %0d cycles, a program never reached its closing store", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction encoders built on the instruction word formats
  function automatic logic [31:0] aluInstr(cpuPkg::aluOp_t op, int rd, int rs1, int rs2);
    cpuPkg::instr_t w;
    logic [2:0]     f3;
    logic [6:0]     f7;
    f7 = (op == cpuPkg::aluSub) ? cpuPkg::f7Sub : 7'b0;
    case (op)
      cpuPkg::aluAnd: f3 = cpuPkg::f3And;
      cpuPkg::aluOr:  f3 = cpuPkg::f3Or;
      cpuPkg::aluXor: f3 = cpuPkg::f3Xor;
      cpuPkg::aluSlt: f3 = cpuPkg::f3Slt;
      default:        f3 = cpuPkg::f3AddSub;
    endcase
    w.rType = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], cpuPkg::opOp};
    return w;
  endfunction

  function automatic logic [31:0] immInstr(logic [6:0] op, int rd, int rs1, int imm);
    cpuPkg::instr_t w;
    logic [2:0]     f3;
    f3 = (op == cpuPkg::opLoad) ? cpuPkg::f3Word : cpuPkg::f3AddSub;
    w.iType = {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    return w;
  endfunction

  function automatic logic [31:0] storeInstr(int rs2, int rs1, int imm);
    cpuPkg::instr_t w;
    w.sType = {imm[11:5], rs2[4:0], rs1[4:0], cpuPkg::f3Word, imm[4:0], cpuPkg::opStore};
    return w;
  endfunction

  function automatic logic [31:0] branchInstr(logic [2:0] f3, int rs1, int rs2, int off);
    cpuPkg::instr_t w;
    w.bType = {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], cpuPkg::opBranch};
    return w;
  endfunction

  function automatic logic [31:0] luiInstr(int rd, int imm20);
    cpuPkg::instr_t w;
    w.uType = {imm20[19:0], rd[4:0], cpuPkg::opLui};
    return w;
  endfunction

  function automatic logic [31:0] jalInstr(int rd, int off);
    cpuPkg::instr_t w;
    w.jType = {off[20], off[10:1], off[11], off[19:12], rd[4:0], cpuPkg::opJal};
    return w;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] fillWord(int idx);
    return 32'hF00D_0000 | (idx << 2); // Unwritten words carry their own address
  endfunction

  function automatic logic [31:0] memWord(int addr);
    return u_mem.mem[addr[9:2]];
  endfunction

  task automatic waitCycles(int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic loadProgram();
    for (int i = 0; i < 256; i++) u_mem.mem[i] = (i < prog.size()) ? prog[i] : fillWord(i);
  endtask

  task automatic compareWord(string name, logic [cpuPkg::xlen-1:0] got,
                             logic [cpuPkg::xlen-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compareAddr(string name, logic [cpuPkg::xlen-1:0] got,
                             logic [cpuPkg::xlen-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Holds the core in reset while the program loads, then runs it up to its last store
  task automatic runProgram(int stores, int busyLimit, int doneAddr);
    waitCycles(1);
    reset   = 1'b1;
    busyMax = busyLimit;
    loadProgram();
    waitCycles(5);
    reset = 1'b0;
    while (storeCount < stores) @(posedge clk);
    compareAddr("lastStoreAddr", lastStoreAddr, doneAddr);
  endtask

  task automatic reportTest(string name, int failsBefore);
    int fails;
    fails = errors + protocolErrors - failsBefore;
    if (fails == 0) $display("Test %s: ok", name);
    else $display("Test %s: %0d errors", name, fails);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic aluResults(string name, int busyLimit);
    int          a, b, failsBefore;
    logic [31:0] expWords [8];
    failsBefore = errors + protocolErrors;
    a           = 1500;
    b           = -700;
    expWords    = '{a + b, a - b, a & b, a | b, a ^ b, (b < a) ? 32'd1 : 32'd0,
                    (a < b) ? 32'd1 : 32'd0, b + 45};
    prog.delete();
    prog.push_back(immInstr(cpuPkg::opOpImm, 1, 0, a));
    prog.push_back(immInstr(cpuPkg::opOpImm, 2, 0, b));
    prog.push_back(aluInstr(cpuPkg::aluAdd, 3, 1, 2));
    prog.push_back(aluInstr(cpuPkg::aluSub, 4, 1, 2));
    prog.push_back(aluInstr(cpuPkg::aluAnd, 5, 1, 2));
    prog.push_back(aluInstr(cpuPkg::aluOr, 6, 1, 2));
    prog.push_back(aluInstr(cpuPkg::aluXor, 7, 1, 2));
    prog.push_back(aluInstr(cpuPkg::aluSlt, 8, 2, 1)); // Negative against positive
    prog.push_back(aluInstr(cpuPkg::aluSlt, 9, 1, 2));
    prog.push_back(immInstr(cpuPkg::opOpImm, 10, 2, 45));
    for (int r = 3; r <= 10; r++) prog.push_back(storeInstr(r, 0, dataBase + 4 * (r - 3)));
    prog.push_back(jalInstr(0, 0));
    runProgram(8, busyLimit, dataBase + 28);
    for (int k = 0; k < 8; k++) begin
      compareWord($sformatf("mem[%0h]", dataBase + 4 * k), memWord(dataBase + 4 * k),
                  expWords[k]);
    end
    reportTest(name, failsBefore);
  endtask

  task automatic luiLoadRoundTrip();
    int failsBefore;
    failsBefore = errors + protocolErrors;
    prog.delete();
    prog.push_back(luiInstr(1, 'h89ABC));
    prog.push_back(immInstr(cpuPkg::opOpImm, 1, 1, 'h5D));
    prog.push_back(storeInstr(1, 0, 'h240));
    prog.push_back(immInstr(cpuPkg::opLoad, 2, 0, 'h240));
    prog.push_back(storeInstr(2, 0, 'h244));
    prog.push_back(jalInstr(0, 0));
    runProgram(2, 0, 'h244);
    compareWord("mem[240]", memWord('h240), {20'h89ABC, 12'h05D});
    compareWord("mem[244]", memWord('h244), {20'h89ABC, 12'h05D});
    reportTest("lui and load", failsBefore);
  endtask

  task automatic branchPaths();
    int failsBefore;
    failsBefore = errors + protocolErrors;
    prog.delete();
    prog.push_back(immInstr(cpuPkg::opOpImm, 1, 0, 5));
    prog.push_back(immInstr(cpuPkg::opOpImm, 2, 0, 5));
    prog.push_back(immInstr(cpuPkg::opOpImm, 3, 0, 7));
    prog.push_back(immInstr(cpuPkg::opOpImm, 4, 0, 1));  // Marker value
    prog.push_back(branchInstr(cpuPkg::f3Beq, 1, 2, 8)); // Taken
    prog.push_back(storeInstr(4, 0, 'h280));
    prog.push_back(branchInstr(cpuPkg::f3Beq, 1, 3, 8)); // Not taken
    prog.push_back(storeInstr(4, 0, 'h284));
    prog.push_back(branchInstr(cpuPkg::f3Bne, 1, 3, 8)); // Taken
    prog.push_back(storeInstr(4, 0, 'h288));
    prog.push_back(branchInstr(cpuPkg::f3Bne, 1, 2, 8)); // Not taken
    prog.push_back(storeInstr(4, 0, 'h28C));
    prog.push_back(storeInstr(4, 0, 'h290));
    prog.push_back(jalInstr(0, 0));
    runProgram(3, 0, 'h290);
    compareWord("mem[280]", memWord('h280), fillWord('h280 >> 2));
    compareWord("mem[284]", memWord('h284), 32'd1);
    compareWord("mem[288]", memWord('h288), fillWord('h288 >> 2));
    compareWord("mem[28c]", memWord('h28C), 32'd1);
    reportTest("branches", failsBefore);
  endtask

  task automatic jalLink();
    int failsBefore;
    failsBefore = errors + protocolErrors;
    prog.delete();
    prog.push_back(immInstr(cpuPkg::opOpImm, 2, 0, 9));
    prog.push_back(jalInstr(1, 12));                     // JAL at address 4
    prog.push_back(immInstr(cpuPkg::opOpImm, 2, 0, 77));
    prog.push_back(storeInstr(2, 0, 'h2C4));
    prog.push_back(storeInstr(1, 0, 'h2C0));
    prog.push_back(storeInstr(2, 0, 'h2C8));
    prog.push_back(jalInstr(0, 0));
    runProgram(2, 0, 'h2C8);
    compareWord("mem[2c0]", memWord('h2C0), 32'd8);
    compareWord("mem[2c4]", memWord('h2C4), fillWord('h2C4 >> 2));
    compareWord("mem[2c8]", memWord('h2C8), 32'd9);
    reportTest("jal", failsBefore);
  endtask

  task automatic zeroRegWrites();
    int failsBefore;
    failsBefore = errors + protocolErrors;
    prog.delete();
    prog.push_back(immInstr(cpuPkg::opOpImm, 1, 0, 55));
    prog.push_back(immInstr(cpuPkg::opOpImm, 0, 0, 123));
    prog.push_back(luiInstr(0, 'h12345));
    prog.push_back(aluInstr(cpuPkg::aluAdd, 0, 1, 1));
    prog.push_back(storeInstr(0, 0, 'h300));
    prog.push_back(jalInstr(0, 0));
    runProgram(1, 0, 'h300);
    compareWord("mem[300]", memWord('h300), 32'd0);
    reportTest("x0 writes", failsBefore);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    reset   = 1'b1;
    enable  = 1'b1;
    busyMax = 0;
    loadProgram();
    aluResults("alu", 0);
    luiLoadRoundTrip();
    branchPaths();
    jalLink();
    zeroRegWrites();
    aluResults("alu with busy", 2);
    $display("Summary: %0d checks, %0d errors, %0d protocol errors", checks, errors,
             protocolErrors);
    if (errors == 0 && protocolErrors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== src.f ====
cpuPkg.sv
cpuControl.sv
cpuRegFile.sv
cpuExecute.sv
cpuPc.sv
cpuRequestUnit.sv
cpuTop.sv
tbMemModel.sv
tbCpuTop.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the core and its testbench with Verilator, runs it and checks the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tbCpuTop -f src.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -F -q '*** PASSED ***' &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }
